//--- include/switch_consts.svh
`ifndef SWITCH_CONSTS_SVH
`define SWITCH_CONSTS_SVH

// Switch size
`define SW_NUM_PORTS 4

// MAC table entries
`define SW_CAM_DEPTH 8

// Frame buffer bytes, shared by all ingress ports
`define SW_BUF_DEPTH 128

// Forwarding decisions waiting for the dispatcher
`define SW_DEC_DEPTH 4

`define SW_BCAST_MAC 48'hFFFF_FFFF_FFFF

`endif

//--- logic/switch_pkg.sv
`default_nettype none

`include "switch_consts.svh"

package switch_pkg;

    typedef logic [$clog2(`SW_NUM_PORTS)-1:0] port_id_t;
    typedef logic [`SW_NUM_PORTS-1:0]         port_mask_t;
    typedef logic [47:0]                      mac_addr_t;

    // One frame byte on any stream
    typedef struct packed {
        logic [7:0] data;
        logic       last;
    } port_beat_t;

    // Shared stream after the arbiter
    typedef struct packed {
        port_beat_t beat;
        port_id_t   port;
    } tagged_beat_t;

    // Empty dest_mask means drop
    typedef struct packed {
        port_mask_t dest_mask;
        port_id_t   src_port;
        logic       flood;
    } fwd_decision_t;

    typedef enum logic [1:0] {
        HDR_DST,
        HDR_SRC,
        HDR_RESOLVE,
        HDR_PAYLOAD
    } lookup_state_e;

    typedef enum logic [1:0] {
        DSP_IDLE,
        DSP_SEND,
        DSP_DISCARD
    } dispatch_state_e;

endpackage

`default_nettype wire

//--- logic/ingress_arbiter.sv
`default_nettype none

`include "switch_consts.svh"

module ingress_arbiter (
    input  wire                                             clock,
    input  wire                                             arst_n,
    input  wire switch_pkg::port_mask_t                     in_valid,
    input  wire switch_pkg::port_beat_t [`SW_NUM_PORTS-1:0] in_beat,
    input  wire                                             arb_ready,

    output switch_pkg::port_mask_t                          in_ready,
    output logic                                            arb_valid,
    output switch_pkg::tagged_beat_t                        arb_beat
);

switch_pkg::port_id_t   grant;
switch_pkg::port_id_t   rr_ptr;
switch_pkg::port_id_t   pick;
logic                   pick_found;
logic                   busy;
logic                   xfer_last;

// First requesting port at or after the pointer
always_comb begin
    pick        = rr_ptr;
    pick_found  = 1'b0;
    for (int i = 0; i < `SW_NUM_PORTS; i++) begin
        if (!pick_found && in_valid[(rr_ptr + i) % `SW_NUM_PORTS]) begin
            pick        = switch_pkg::port_id_t'((rr_ptr + i) % `SW_NUM_PORTS);
            pick_found  = 1'b1;
        end
    end
end

always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
        busy    <= 1'b0;
        grant   <= '0;
        rr_ptr  <= '0;
    end else if (!busy) begin
        if (pick_found) begin
            busy    <= 1'b1;
            grant   <= pick;
        end
    end else if (xfer_last) begin
        busy    <= 1'b0;
        rr_ptr  <= switch_pkg::port_id_t'((grant + 1) % `SW_NUM_PORTS);
    end
end

// Granted port straight through
assign arb_valid        = busy && in_valid[grant];
assign arb_beat.beat    = in_beat[grant];
assign arb_beat.port    = grant;
assign in_ready         = busy ? (switch_pkg::port_mask_t'(arb_ready) << grant) : '0;
assign xfer_last        = arb_valid && arb_ready && arb_beat.beat.last;

// Granted beat held until both lookup and buffer take it
assert property (@(posedge clock) disable iff (!arst_n)
    arb_valid && !arb_ready |=> arb_valid && $stable(arb_beat));

endmodule

`default_nettype wire

//--- logic/mac_lookup.sv
`default_nettype none

`include "switch_consts.svh"

module mac_lookup (
    input  wire                             clock,
    input  wire                             arst_n,
    input  wire                             arb_valid,
    input  wire                             arb_ready,
    input  wire switch_pkg::tagged_beat_t   arb_beat,
    input  wire                             dec_ready,

    output logic                            hdr_ready,
    output logic                            dec_valid,
    output switch_pkg::fwd_decision_t       dec
);

localparam int CAM_W = $clog2(`SW_CAM_DEPTH);
localparam int DEC_W = $clog2(`SW_DEC_DEPTH);

switch_pkg::lookup_state_e  state;
logic [3:0]                 byte_cnt;
logic                       resolve_phase;
logic                       xfer;
logic                       learn;

switch_pkg::mac_addr_t      dst_mac;
switch_pkg::mac_addr_t      src_mac;
switch_pkg::port_id_t       src_port;

switch_pkg::mac_addr_t      cam_mac  [`SW_CAM_DEPTH];
switch_pkg::port_id_t       cam_port [`SW_CAM_DEPTH];
logic [`SW_CAM_DEPTH-1:0]   cam_valid;
logic [CAM_W-1:0]           repl_ptr;

logic                       dst_hit;
switch_pkg::port_id_t       dst_port;
logic                       src_hit;
logic [CAM_W-1:0]           src_idx;
logic                       free_found;
logic [CAM_W-1:0]           free_idx;
logic [CAM_W-1:0]           learn_idx;

switch_pkg::fwd_decision_t  dec_new;
switch_pkg::fwd_decision_t  dec_q;
switch_pkg::fwd_decision_t  dec_mem [`SW_DEC_DEPTH];
logic [DEC_W-1:0]           dec_wr_ptr;
logic [DEC_W-1:0]           dec_rd_ptr;
logic [DEC_W:0]             dec_count;
logic                       dec_full;
logic                       push;
logic                       pop;

assign xfer     = arb_valid && arb_ready;
assign learn    = (state == switch_pkg::HDR_RESOLVE) && !resolve_phase;
assign push     = (state == switch_pkg::HDR_RESOLVE) && resolve_phase;
assign pop      = dec_valid && dec_ready;
assign dec_full = dec_count == `SW_DEC_DEPTH;

always_comb begin
    case (state)
        switch_pkg::HDR_DST,
        switch_pkg::HDR_SRC:     hdr_ready = !dec_full;
        switch_pkg::HDR_RESOLVE: hdr_ready = 1'b0;
        default:                 hdr_ready = 1'b1;
    endcase
end

////////////////////////////////////////////////////////////////////////////
// Header capture
////////////////////////////////////////////////////////////////////////////

always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
        state           <= switch_pkg::HDR_DST;
        byte_cnt        <= '0;
        resolve_phase   <= 1'b0;
    end else begin
        case (state)
            switch_pkg::HDR_DST,
            switch_pkg::HDR_SRC: begin
                if (xfer) begin
                    byte_cnt <= byte_cnt + 4'd1;
                    if (byte_cnt == 4'd5) begin
                        state <= switch_pkg::HDR_SRC;
                    end
                    if (byte_cnt == 4'd11) begin
                        byte_cnt    <= '0;
                        state       <= switch_pkg::HDR_RESOLVE;
                    end
                end
            end
            switch_pkg::HDR_RESOLVE: begin
                resolve_phase <= !resolve_phase;
                if (resolve_phase) begin
                    state <= switch_pkg::HDR_PAYLOAD;
                end
            end
            default: begin
                if (xfer && arb_beat.beat.last) begin
                    state <= switch_pkg::HDR_DST;
                end
            end
        endcase
    end
end

// Address bytes arrive most significant first
always_ff @(posedge clock) begin
    if (xfer && state == switch_pkg::HDR_DST) begin
        dst_mac     <= {dst_mac[39:0], arb_beat.beat.data};
        src_port    <= arb_beat.port;
    end
    if (xfer && state == switch_pkg::HDR_SRC) begin
        src_mac <= {src_mac[39:0], arb_beat.beat.data};
    end
    if (learn) begin
        dec_q <= dec_new;
    end
end

////////////////////////////////////////////////////////////////////////////
// CAM compare and learning
////////////////////////////////////////////////////////////////////////////

always_comb begin
    dst_hit     = 1'b0;
    dst_port    = '0;
    src_hit     = 1'b0;
    src_idx     = '0;
    free_found  = 1'b0;
    free_idx    = '0;
    for (int i = 0; i < `SW_CAM_DEPTH; i++) begin
        if (cam_valid[i] && cam_mac[i] == dst_mac && !dst_hit) begin
            dst_hit     = 1'b1;
            dst_port    = cam_port[i];
        end
        if (cam_valid[i] && cam_mac[i] == src_mac && !src_hit) begin
            src_hit = 1'b1;
            src_idx = CAM_W'(i);
        end
        if (!cam_valid[i] && !free_found) begin
            free_found  = 1'b1;
            free_idx    = CAM_W'(i);
        end
    end
end

assign learn_idx = src_hit ? src_idx : (free_found ? free_idx : repl_ptr);

always_comb begin
    dec_new.src_port    = src_port;
    dec_new.flood       = (dst_mac == `SW_BCAST_MAC) || !dst_hit;
    if (dec_new.flood) begin
        dec_new.dest_mask = ~(switch_pkg::port_mask_t'(1) << src_port);
    end else if (dst_port == src_port) begin
        dec_new.dest_mask = '0;
    end else begin
        dec_new.dest_mask = switch_pkg::port_mask_t'(1) << dst_port;
    end
end

always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
        cam_valid   <= '0;
        repl_ptr    <= '0;
    end else if (learn) begin
        cam_valid[learn_idx] <= 1'b1;
        if (!src_hit && !free_found) begin
            repl_ptr <= repl_ptr + 1'b1;
        end
    end
end

always_ff @(posedge clock) begin
    if (learn) begin
        cam_mac[learn_idx]  <= src_mac;
        cam_port[learn_idx] <= src_port;
    end
end

////////////////////////////////////////////////////////////////////////////
// Decision queue
////////////////////////////////////////////////////////////////////////////

always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
        dec_wr_ptr  <= '0;
        dec_rd_ptr  <= '0;
        dec_count   <= '0;
    end else begin
        if (push) begin
            dec_wr_ptr <= dec_wr_ptr + 1'b1;
        end
        if (pop) begin
            dec_rd_ptr <= dec_rd_ptr + 1'b1;
        end
        if (push && !pop) begin
            dec_count <= dec_count + 1'b1;
        end else if (pop && !push) begin
            dec_count <= dec_count - 1'b1;
        end
    end
end

always_ff @(posedge clock) begin
    if (push) begin
        dec_mem[dec_wr_ptr] <= dec_q;
    end
end

assign dec_valid    = dec_count != '0;
assign dec          = dec_mem[dec_rd_ptr];

// Frames shorter than the header are not supported
assert property (@(posedge clock) disable iff (!arst_n)
    xfer && arb_beat.beat.last |-> state == switch_pkg::HDR_PAYLOAD);

// Space was reserved while the header came in
assert property (@(posedge clock) disable iff (!arst_n)
    push |-> !dec_full || pop);

endmodule

`default_nettype wire

//--- logic/frame_buffer.sv
`default_nettype none

`include "switch_consts.svh"

module frame_buffer (
    input  wire                             clock,
    input  wire                             arst_n,
    input  wire                             wr_valid,
    input  wire switch_pkg::port_beat_t     wr_beat,
    input  wire                             rd_ready,

    output logic                            wr_ready,
    output logic                            rd_valid,
    output switch_pkg::port_beat_t          rd_beat
);

localparam int PTR_W = $clog2(`SW_BUF_DEPTH);

switch_pkg::port_beat_t mem [`SW_BUF_DEPTH];
logic [PTR_W-1:0]       wr_ptr;
logic [PTR_W-1:0]       rd_ptr;
logic [PTR_W:0]         count;
logic                   rd_xfer;

assign rd_xfer  = rd_valid && rd_ready;
assign wr_ready = count != `SW_BUF_DEPTH;
assign rd_valid = count != '0;
assign rd_beat  = mem[rd_ptr];

always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
        wr_ptr  <= '0;
        rd_ptr  <= '0;
        count   <= '0;
    end else begin
        if (wr_valid) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
        if (rd_xfer) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
        if (wr_valid && !rd_xfer) begin
            count <= count + 1'b1;
        end else if (rd_xfer && !wr_valid) begin
            count <= count - 1'b1;
        end
    end
end

// Write strobe is already a completed transfer
always_ff @(posedge clock) begin
    if (wr_valid) begin
        mem[wr_ptr] <= wr_beat;
    end
end

// Upstream ready must include buffer space
assert property (@(posedge clock) disable iff (!arst_n)
    wr_valid |-> wr_ready);

endmodule

`default_nettype wire

//--- logic/egress_dispatch.sv
`default_nettype none

module egress_dispatch (
    input  wire                             clock,
    input  wire                             arst_n,
    input  wire                             dec_valid,
    input  wire switch_pkg::fwd_decision_t  dec,
    input  wire                             buf_valid,
    input  wire switch_pkg::port_beat_t     buf_beat,
    input  wire switch_pkg::port_mask_t     out_ready,

    output logic                            dec_ready,
    output logic                            buf_ready,
    output switch_pkg::port_mask_t          out_valid,
    output switch_pkg::port_beat_t          out_beat
);

switch_pkg::dispatch_state_e    state;
switch_pkg::port_mask_t         mask_q;
logic                           all_ready;
logic                           buf_last;

// Unmasked ports never hold a beat back
assign all_ready    = &(out_ready | ~mask_q);
assign buf_last     = buf_valid && buf_ready && buf_beat.last;

assign dec_ready    = (state == switch_pkg::DSP_IDLE) && buf_valid;
assign buf_ready    = ((state == switch_pkg::DSP_SEND) && all_ready) ||
                      (state == switch_pkg::DSP_DISCARD);
assign out_valid    = ((state == switch_pkg::DSP_SEND) && buf_valid) ? mask_q : '0;
assign out_beat     = buf_beat;

always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
        state   <= switch_pkg::DSP_IDLE;
        mask_q  <= '0;
    end else begin
        case (state)
            switch_pkg::DSP_IDLE: begin
                if (dec_valid && dec_ready) begin
                    mask_q  <= dec.dest_mask;
                    state   <= (|dec.dest_mask) ? switch_pkg::DSP_SEND
                                                : switch_pkg::DSP_DISCARD;
                end
            end
            default: begin
                if (buf_last) begin
                    state <= switch_pkg::DSP_IDLE;
                end
            end
        endcase
    end
end

// A flooded frame never returns to its source
assert property (@(posedge clock) disable iff (!arst_n)
    dec_valid && dec.flood |-> !dec.dest_mask[dec.src_port]);

// Stalled output holds until every masked port takes it
assert property (@(posedge clock) disable iff (!arst_n)
    (|out_valid) && !all_ready |=> (out_valid == $past(out_valid)) &&
                                   (out_beat == $past(out_beat)));

endmodule

`default_nettype wire

//--- logic/switch_core.sv
`default_nettype none

`include "switch_consts.svh"

module switch_core (
    input  wire                                             clock,
    input  wire                                             arst_n,
    input  wire switch_pkg::port_mask_t                     in_valid,
    input  wire switch_pkg::port_beat_t [`SW_NUM_PORTS-1:0] in_beat,
    input  wire switch_pkg::port_mask_t                     out_ready,

    output switch_pkg::port_mask_t                          in_ready,
    output switch_pkg::port_mask_t                          out_valid,
    output switch_pkg::port_beat_t                          out_beat
);

wire                                arb_valid;
wire                                arb_ready;
wire switch_pkg::tagged_beat_t      arb_beat;
wire                                hdr_ready;
wire                                wr_ready;
wire                                buf_write;

wire                                dec_valid;
wire                                dec_ready;
wire switch_pkg::fwd_decision_t     dec;

wire                                buf_valid;
wire                                buf_ready;
wire switch_pkg::port_beat_t        buf_beat;

// Both lookup and buffer take every beat together
assign arb_ready    = wr_ready && hdr_ready;
assign buf_write    = arb_valid && arb_ready;

ingress_arbiter ingress_arbiter (
    .clock      (clock),
    .arst_n     (arst_n),
    .in_valid   (in_valid),
    .in_beat    (in_beat),
    .arb_ready  (arb_ready),
    .in_ready   (in_ready),
    .arb_valid  (arb_valid),
    .arb_beat   (arb_beat)
);

mac_lookup mac_lookup (
    .clock      (clock),
    .arst_n     (arst_n),
    .arb_valid  (arb_valid),
    .arb_ready  (arb_ready),
    .arb_beat   (arb_beat),
    .dec_ready  (dec_ready),
    .hdr_ready  (hdr_ready),
    .dec_valid  (dec_valid),
    .dec        (dec)
);

frame_buffer frame_buffer (
    .clock      (clock),
    .arst_n     (arst_n),
    .wr_valid   (buf_write),
    .wr_beat    (arb_beat.beat),
    .rd_ready   (buf_ready),
    .wr_ready   (wr_ready),
    .rd_valid   (buf_valid),
    .rd_beat    (buf_beat)
);

egress_dispatch egress_dispatch (
    .clock      (clock),
    .arst_n     (arst_n),
    .dec_valid  (dec_valid),
    .dec        (dec),
    .buf_valid  (buf_valid),
    .buf_beat   (buf_beat),
    .out_ready  (out_ready),
    .dec_ready  (dec_ready),
    .buf_ready  (buf_ready),
    .out_valid  (out_valid),
    .out_beat   (out_beat)
);

endmodule

`default_nettype wire

//--- verif/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
    output logic clock
);

timeunit 1ns;
timeprecision 1ps;

// 40 ns period
initial begin
    clock = 1'b0;
    forever begin
        #20 clock = ~clock;
    end
end

endmodule

`default_nettype wire

//--- verif/switch_core_tb.sv
`default_nettype none

`include "switch_consts.svh"

module switch_core_tb;

timeunit 1ns;
timeprecision 1ps;

typedef struct packed {
    switch_pkg::port_id_t   port;
    switch_pkg::mac_addr_t  dst;
    switch_pkg::mac_addr_t  src;
    logic [7:0]             len;
    logic [7:0]             seed;
    logic                   stall;
} frame_row_t;

localparam int NUM_ROWS   = 21;
localparam int MAX_LEN    = 12 + 20;
localparam int WAIT_LIMIT = 4000;

localparam switch_pkg::port_mask_t ALL_PORTS = '1;

localparam switch_pkg::mac_addr_t MAC_A = 48'h0200_0000_000a;
localparam switch_pkg::mac_addr_t MAC_B = 48'h0200_0000_000b;
localparam switch_pkg::mac_addr_t MAC_D = 48'h0200_0000_000d;
localparam switch_pkg::mac_addr_t MAC_E = 48'h0200_0000_000e;
localparam switch_pkg::mac_addr_t MAC_F = 48'h0200_0000_000f;
localparam switch_pkg::mac_addr_t MAC_G = 48'h0200_0000_0010;
localparam switch_pkg::mac_addr_t MAC_H = 48'h0200_0000_0011;
localparam switch_pkg::mac_addr_t MAC_I = 48'h0200_0000_0012;
localparam switch_pkg::mac_addr_t BCAST = `SW_BCAST_MAC;

logic                                               clock;
logic                                               arst_n;
switch_pkg::port_mask_t                             in_valid;
switch_pkg::port_beat_t [`SW_NUM_PORTS-1:0]         in_beat;
switch_pkg::port_mask_t                             in_ready;
switch_pkg::port_mask_t                             out_valid;
switch_pkg::port_beat_t                             out_beat;
switch_pkg::port_mask_t                             out_ready;

frame_row_t                 rows       [NUM_ROWS];
switch_pkg::port_beat_t     frame_data [NUM_ROWS][MAX_LEN];
int                         frame_len  [NUM_ROWS];
switch_pkg::port_mask_t     exp_mask   [NUM_ROWS];

// Reference MAC table
switch_pkg::mac_addr_t      model_mac  [`SW_CAM_DEPTH];
switch_pkg::port_id_t       model_port [`SW_CAM_DEPTH];
logic                       model_used [`SW_CAM_DEPTH];
int                         model_next;

switch_pkg::port_beat_t     rx      [`SW_NUM_PORTS][$];
switch_pkg::port_mask_t     rx_mask [`SW_NUM_PORTS];
int                         pend    [`SW_NUM_PORTS][$];

switch_pkg::port_mask_t     stall_pat [256];
logic [7:0]                 stall_idx;
logic                       stall_mode;

tb_clock_gen clock_gen_inst (
    .clock  (clock)
);

switch_core switch_core_inst (
    .clock      (clock),
    .arst_n     (arst_n),
    .in_valid   (in_valid),
    .in_beat    (in_beat),
    .out_ready  (out_ready),
    .in_ready   (in_ready),
    .out_valid  (out_valid),
    .out_beat   (out_beat)
);

////////////////////////////////////////////////////////////////////////////
// Checks
////////////////////////////////////////////////////////////////////////////

task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1);
endtask

task automatic check_beat(input string name, input switch_pkg::port_beat_t got,
                          input switch_pkg::port_beat_t exp);
    if (got !== exp) begin
        fail_run($sformatf("Mismatch %s: data %h last %h, expected data %h last %h",
                           name, got.data, got.last, exp.data, exp.last));
    end
endtask

task automatic check_mask(input string name, input switch_pkg::port_mask_t got,
                          input switch_pkg::port_mask_t exp);
    if (got !== exp) begin
        fail_run($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
    end
endtask

////////////////////////////////////////////////////////////////////////////
// Reference model
////////////////////////////////////////////////////////////////////////////

// Lookup first, then learn the source
function automatic switch_pkg::port_mask_t predict_mask(input frame_row_t row);
    switch_pkg::port_mask_t mask;
    int dst_slot;
    int src_slot;
    int free_slot;
    dst_slot  = -1;
    src_slot  = -1;
    free_slot = -1;
    for (int i = 0; i < `SW_CAM_DEPTH; i++) begin
        if (model_used[i] && model_mac[i] == row.dst && dst_slot < 0) dst_slot = i;
        if (model_used[i] && model_mac[i] == row.src && src_slot < 0) src_slot = i;
        if (!model_used[i] && free_slot < 0) free_slot = i;
    end
    if (row.dst == BCAST || dst_slot < 0) begin
        mask = ALL_PORTS & ~(switch_pkg::port_mask_t'(1) << row.port);
    end else if (model_port[dst_slot] == row.port) begin
        mask = '0;
    end else begin
        mask = switch_pkg::port_mask_t'(1) << model_port[dst_slot];
    end
    if (src_slot < 0 && free_slot >= 0) begin
        src_slot = free_slot;
    end else if (src_slot < 0) begin
        src_slot   = model_next;
        model_next = (model_next + 1) % `SW_CAM_DEPTH;
    end
    model_used[src_slot] = 1'b1;
    model_mac[src_slot]  = row.src;
    model_port[src_slot] = row.port;
    return mask;
endfunction

task automatic load_table();
    // Unknown destination, reply, then unicast
    rows[0]  = '{2'd0, MAC_B, MAC_A, 8'd9,  8'h5a, 1'b0};
    rows[1]  = '{2'd1, MAC_A, MAC_B, 8'd4,  8'h11, 1'b0};
    rows[2]  = '{2'd0, MAC_B, MAC_A, 8'd17, 8'hc3, 1'b0};
    // Broadcast seen as a source, then as a destination
    rows[3]  = '{2'd2, BCAST, BCAST, 8'd6,  8'h70, 1'b0};
    rows[4]  = '{2'd3, BCAST, MAC_D, 8'd1,  8'h0f, 1'b0};
    // Destination on own port is dropped
    rows[5]  = '{2'd0, MAC_A, MAC_A, 8'd12, 8'h99, 1'b0};
    rows[6]  = '{2'd1, MAC_D, MAC_B, 8'd3,  8'h2e, 1'b0};
    // Fill the table, then replace entry 0
    rows[7]  = '{2'd2, MAC_B, MAC_E, 8'd5,  8'h41, 1'b0};
    rows[8]  = '{2'd2, MAC_B, MAC_F, 8'd8,  8'hb7, 1'b0};
    rows[9]  = '{2'd3, MAC_B, MAC_G, 8'd2,  8'h6d, 1'b0};
    rows[10] = '{2'd3, MAC_B, MAC_H, 8'd11, 8'he0, 1'b0};
    rows[11] = '{2'd2, MAC_B, MAC_I, 8'd7,  8'h38, 1'b0};
    rows[12] = '{2'd1, MAC_A, MAC_B, 8'd10, 8'hd4, 1'b0};
    // Several ports at once with output stalls
    rows[13] = '{2'd1, MAC_D, MAC_B, 8'd20, 8'h01, 1'b1};
    rows[14] = '{2'd2, MAC_B, MAC_E, 8'd15, 8'h82, 1'b1};
    rows[15] = '{2'd3, MAC_E, MAC_D, 8'd9,  8'h13, 1'b1};
    rows[16] = '{2'd1, BCAST, MAC_B, 8'd6,  8'ha4, 1'b1};
    rows[17] = '{2'd2, MAC_D, MAC_F, 8'd18, 8'h55, 1'b1};
    rows[18] = '{2'd3, MAC_B, MAC_G, 8'd3,  8'hf6, 1'b1};
    rows[19] = '{2'd1, MAC_E, MAC_B, 8'd13, 8'h27, 1'b1};
    rows[20] = '{2'd3, BCAST, MAC_H, 8'd19, 8'h68, 1'b1};
endtask

// Header bytes go most significant first
task automatic build_frames();
    switch_pkg::port_beat_t beat;
    int n;
    for (int i = 0; i < `SW_CAM_DEPTH; i++) begin
        model_used[i] = 1'b0;
    end
    model_next = 0;
    for (int r = 0; r < NUM_ROWS; r++) begin
        exp_mask[r]  = predict_mask(rows[r]);
        n            = 12 + int'(rows[r].len);
        frame_len[r] = n;
        for (int i = 0; i < n; i++) begin
            if (i < 6) begin
                beat.data = rows[r].dst[47 - 8*i -: 8];
            end else if (i < 12) begin
                beat.data = rows[r].src[47 - 8*(i - 6) -: 8];
            end else begin
                beat.data = 8'($urandom) ^ rows[r].seed;
            end
            beat.last          = (i == n - 1);
            frame_data[r][i]   = beat;
        end
    end
endtask

////////////////////////////////////////////////////////////////////////////
// Stimulus
////////////////////////////////////////////////////////////////////////////

task automatic send_frame(input int r);
    int p;
    int waited;
    p = int'(rows[r].port);
    @(posedge clock);
    for (int i = 0; i < frame_len[r]; i++) begin
        in_valid[p] <= 1'b1;
        in_beat[p]  <= frame_data[r][i];
        waited = 0;
        do begin
            @(negedge clock);
            waited++;
            if (waited > WAIT_LIMIT) begin
                fail_run($sformatf("Timeout: port %0d never accepted byte %0d of frame %0d",
                                   p, i, r));
            end
        end while (!in_ready[p]);
        @(posedge clock);
    end
    in_valid[p] <= 1'b0;
endtask

task automatic send_port_frames(input int p);
    for (int r = 0; r < NUM_ROWS; r++) begin
        if (rows[r].stall && int'(rows[r].port) == p) begin
            send_frame(r);
        end
    end
endtask

task automatic queue_expect(input int r);
    for (int p = 0; p < `SW_NUM_PORTS; p++) begin
        if (exp_mask[r][p]) begin
            pend[p].push_back(r);
        end
    end
endtask

function automatic int pending_total();
    int total;
    total = 0;
    for (int p = 0; p < `SW_NUM_PORTS; p++) begin
        total += pend[p].size() + rx[p].size();
    end
    return total;
endfunction

task automatic wait_drained();
    int waited;
    waited = 0;
    while (pending_total() != 0) begin
        @(posedge clock);
        waited++;
        if (waited > WAIT_LIMIT) begin
            fail_run("Timeout: expected frames never left the switch");
        end
    end
endtask

always @(posedge clock) begin
    if (stall_mode) begin
        out_ready <= stall_pat[stall_idx];
        stall_idx <= stall_idx + 8'd1;
    end else begin
        out_ready <= ALL_PORTS;
    end
end

////////////////////////////////////////////////////////////////////////////
// Egress monitor
////////////////////////////////////////////////////////////////////////////

// Match by source address, oldest pending frame from that source first
task automatic finish_frame(input int p);
    switch_pkg::mac_addr_t seen_src;
    int slot;
    int row;
    seen_src = '0;
    slot     = -1;
    if (rx[p].size() < 12) begin
        fail_run($sformatf("Frame on port %0d ended after %0d bytes, inside its header",
                           p, rx[p].size()));
    end
    for (int i = 6; i < 12; i++) begin
        seen_src = {seen_src[39:0], rx[p][i].data};
    end
    for (int k = 0; k < pend[p].size() && slot < 0; k++) begin
        if (rows[pend[p][k]].src == seen_src) slot = k;
    end
    if (slot < 0) begin
        fail_run($sformatf("Unexpected frame from source %h on port %0d", seen_src, p));
    end
    row = pend[p][slot];
    check_mask($sformatf("out_valid frame %0d", row), rx_mask[p], exp_mask[row]);
    if (rx[p].size() != frame_len[row]) begin
        fail_run($sformatf("Mismatch frame length port %0d: got %h, expected %h",
                           p, rx[p].size(), frame_len[row]));
    end
    for (int i = 0; i < frame_len[row]; i++) begin
        check_beat($sformatf("out_beat port %0d byte %0d", p, i),
                   rx[p][i], frame_data[row][i]);
    end
    pend[p].delete(slot);
    rx[p].delete();
endtask

// A beat leaves once every masked port is ready
always @(negedge clock) begin
    if (arst_n && out_valid != '0 && (&(out_ready | ~out_valid))) begin
        for (int p = 0; p < `SW_NUM_PORTS; p++) begin
            if (out_valid[p]) begin
                if (rx[p].size() == 0) rx_mask[p] = out_valid;
                rx[p].push_back(out_beat);
                if (out_beat.last) finish_frame(p);
            end
        end
    end
end

initial begin
    arst_n     = 1'b0;
    in_valid   = '0;
    in_beat    = '0;
    out_ready  = '0;
    stall_idx  = '0;
    stall_mode = 1'b0;
    void'($urandom(32'h73720de3));
    load_table();
    build_frames();
    for (int i = 0; i < 256; i++) begin
        stall_pat[i] = switch_pkg::port_mask_t'($urandom | $urandom);
    end

    repeat (10) @(posedge clock);
    arst_n <= 1'b1;
    @(posedge clock);
    @(negedge clock);
    check_mask("in_ready", in_ready, '0);
    check_mask("out_valid", out_valid, '0);

    // One frame at a time
    for (int r = 0; r < NUM_ROWS; r++) begin
        if (!rows[r].stall) begin
            queue_expect(r);
            send_frame(r);
            wait_drained();
        end
    end

    // All remaining frames together
    @(posedge clock);
    stall_mode <= 1'b1;
    for (int r = 0; r < NUM_ROWS; r++) begin
        if (rows[r].stall) queue_expect(r);
    end
    fork
        send_port_frames(0);
        send_port_frames(1);
        send_port_frames(2);
        send_port_frames(3);
    join
    wait_drained();

    $display("TEST PASS");
    $finish;
end

endmodule

`default_nettype wire

//--- flist.f
+incdir+include
logic/switch_pkg.sv
logic/ingress_arbiter.sv
logic/mac_lookup.sv
logic/frame_buffer.sv
logic/egress_dispatch.sv
logic/switch_core.sv
verif/tb_clock_gen.sv
verif/switch_core_tb.sv

//--- Bender.yml
package:
  name: switch_core

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/switch_pkg.sv
      - logic/ingress_arbiter.sv
      - logic/mac_lookup.sv
      - logic/frame_buffer.sv
      - logic/egress_dispatch.sv
      - logic/switch_core.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/tb_clock_gen.sv
      - verif/switch_core_tb.sv
